/* include/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Processor byte address width
`define CACHE_ADDR_W 16

// Data word width on the processor port and on the backing memory
`define CACHE_WORD_W 16

`endif

/* design/cache_pkg.sv */
package cache_pkg;

    localparam int TAG_W = 5;
    localparam int IDX_W = 8;
    localparam int OFS_W = 3;
    localparam int WORD_W = 16;
    localparam int SETS = 256;
    localparam int WORDS_PER_LINE = 4;
    localparam int ADDR_W = TAG_W + IDX_W + OFS_W;
    localparam int MEM_WORDS = 2 ** (ADDR_W - 1); // Backing store is word addressed
    localparam int MEM_LAT = 2; // Read latency of the backing memory in cycles
    localparam logic [WORD_W-1:0] MEM_INIT_KEY = 16'hA5C3;

    // Controller states
    typedef enum logic [3:0] {
        IDLE,
        COMP_RD,
        COMP_WR,
        WB_0,
        WB_1,
        WB_2,
        WB_3,
        FILL_0,
        FILL_1,
        FILL_2,
        FILL_3,
        FILL_4,
        FILL_5
    } cache_state_e;

    typedef enum logic [1:0] {NONE, READ, WRITE} mem_op_e;

endpackage

/* design/cache_if.sv */
interface cache_way_if;
    logic                              enable;
    logic                              way;
    logic [cache_pkg::IDX_W-1:0]       index;
    logic [cache_pkg::OFS_W-1:0]       offset;
    logic [cache_pkg::TAG_W-1:0]       tag;
    logic                              comp;
    logic                              write;
    logic                              valid_in;
    logic                              dirty_in;
    logic [cache_pkg::WORD_W-1:0]      wdata;
    logic [cache_pkg::TAG_W-1:0]       tag_out [2]; // One entry per way
    logic                              valid [2];
    logic                              dirty [2];
    logic [cache_pkg::WORD_W-1:0]      rdata [2];

    modport ctrl (output enable, way, index, offset, tag, comp, write, valid_in, dirty_in,
                  wdata, input rdata);
    modport array (input enable, way, index, offset, tag, comp, write, valid_in, dirty_in,
                   wdata, output tag_out, valid, dirty, rdata);
    modport lookup (input tag, tag_out, valid, dirty);
endinterface

interface mem_if;
    cache_pkg::mem_op_e                op;
    logic [cache_pkg::ADDR_W-1:0]      addr; // Byte address, bit 0 unused
    logic [cache_pkg::WORD_W-1:0]      wdata;
    logic [cache_pkg::WORD_W-1:0]      rdata;

    modport ctrl (output op, addr, wdata, input rdata);
    modport mem (input op, addr, wdata, output rdata);
endinterface

/* design/cache_way_array.sv */
module cache_way_array (
    input logic        clk,
    input logic        arst_n,
    cache_way_if.array way_bus
);

    logic [cache_pkg::IDX_W+1:0] word_addr;

    // Set index plus word within the line
    assign word_addr = {way_bus.index, way_bus.offset[cache_pkg::OFS_W-1:1]};

    for (genvar g = 0; g < 2; g++) begin : g_way
        logic [cache_pkg::WORD_W-1:0] data_mem [cache_pkg::SETS * cache_pkg::WORDS_PER_LINE];
        logic [cache_pkg::TAG_W-1:0]  tag_mem [cache_pkg::SETS];
        logic [cache_pkg::SETS-1:0]   valid_q;
        logic [cache_pkg::SETS-1:0]   dirty_q;
        logic                         wr_en;

        assign wr_en = way_bus.enable && way_bus.write && (way_bus.way == 1'(g));

        always_ff @(posedge clk) begin
            if (wr_en) begin
                data_mem[word_addr] <= way_bus.wdata;
                if (!way_bus.comp) begin
                    tag_mem[way_bus.index] <= way_bus.tag; // Fill installs a new tag
                end
            end
        end

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                valid_q <= '0;
                dirty_q <= '0;
            end else if (wr_en) begin
                // A compare write is a hit on a valid line and only marks it dirty
                if (way_bus.comp) begin
                    dirty_q[way_bus.index] <= 1'b1;
                end else begin
                    valid_q[way_bus.index] <= way_bus.valid_in;
                    dirty_q[way_bus.index] <= way_bus.dirty_in;
                end
            end
        end

        assign way_bus.tag_out[g] = tag_mem[way_bus.index];
        assign way_bus.valid[g]   = valid_q[way_bus.index];
        assign way_bus.dirty[g]   = dirty_q[way_bus.index];
        assign way_bus.rdata[g]   = data_mem[word_addr];
    end

endmodule

/* design/cache_lookup.sv */
module cache_lookup (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        fill_done,
    cache_way_if.lookup                 way_bus,
    output logic                        hit,
    output logic                        hit_way,
    output logic                        victim_way,
    output logic                        victim_dirty,
    output logic [cache_pkg::TAG_W-1:0] victim_tag
);

    logic       victim_q;
    logic [1:0] way_hit;

    assign way_hit[0] = way_bus.valid[0] && (way_bus.tag_out[0] == way_bus.tag);
    assign way_hit[1] = way_bus.valid[1] && (way_bus.tag_out[1] == way_bus.tag);

    assign hit     = |way_hit;
    assign hit_way = way_hit[1]; // Both ways never hold the same tag

    // Empty ways are used first, the victim bit only decides between two valid ways
    assign victim_way = !way_bus.valid[0] ? 1'b0 :
                        !way_bus.valid[1] ? 1'b1 : victim_q;

    assign victim_dirty = way_bus.valid[victim_way] && way_bus.dirty[victim_way];
    assign victim_tag   = way_bus.tag_out[victim_way];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            victim_q <= 1'b0;
        end else if (fill_done) begin
            victim_q <= !victim_q;
        end
    end

endmodule

/* design/cache_ctrl.sv */
module cache_ctrl (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [cache_pkg::ADDR_W-1:0] addr,
    input  logic [cache_pkg::WORD_W-1:0] data_in,
    input  logic                         rd,
    input  logic                         wr,
    cache_way_if.ctrl                    way_bus,
    mem_if.ctrl                          mem_bus,
    input  logic                         hit,
    input  logic                         hit_way,
    input  logic                         victim_way,
    input  logic                         victim_dirty,
    input  logic [cache_pkg::TAG_W-1:0]  victim_tag,
    output logic                         fill_done,
    output logic [cache_pkg::WORD_W-1:0] data_out,
    output logic                         done,
    output logic                         stall,
    output logic                         cache_hit
);

    cache_pkg::cache_state_e      state;
    cache_pkg::cache_state_e      next_state;
    logic                         vic_way_q;
    logic                         is_wr_q;
    logic [cache_pkg::WORD_W-1:0] rd_word_q;
    logic [cache_pkg::TAG_W-1:0]  req_tag;
    logic [cache_pkg::IDX_W-1:0]  req_idx;
    logic [1:0]                   req_word;
    logic                         compare;
    logic                         wb_active;
    logic                         rd_issue;
    logic                         fill_land;
    logic                         fill_hit_word;
    logic [1:0]                   wb_word;
    logic [1:0]                   issue_word;
    logic [1:0]                   land_word;

    assign req_tag  = addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
    assign req_idx  = addr[cache_pkg::OFS_W +: cache_pkg::IDX_W];
    assign req_word = addr[cache_pkg::OFS_W-1:1];
    assign compare  = (state == cache_pkg::COMP_RD) || (state == cache_pkg::COMP_WR);

    always_comb begin
        next_state = state;
        wb_active  = 1'b0;
        rd_issue   = 1'b0;
        fill_land  = 1'b0;
        wb_word    = 2'd0;
        issue_word = 2'd0;
        land_word  = 2'd0;
        case (state)
            cache_pkg::IDLE: begin
                if (rd) next_state = cache_pkg::COMP_RD;
                else if (wr) next_state = cache_pkg::COMP_WR;
            end
            cache_pkg::COMP_RD, cache_pkg::COMP_WR: begin
                if (hit) next_state = cache_pkg::IDLE;
                else if (victim_dirty) next_state = cache_pkg::WB_0;
                else next_state = cache_pkg::FILL_0;
            end
            cache_pkg::WB_0: begin
                wb_active  = 1'b1;
                next_state = cache_pkg::WB_1;
            end
            cache_pkg::WB_1: begin
                wb_active  = 1'b1;
                wb_word    = 2'd1;
                next_state = cache_pkg::WB_2;
            end
            cache_pkg::WB_2: begin
                wb_active  = 1'b1;
                wb_word    = 2'd2;
                next_state = cache_pkg::WB_3;
            end
            cache_pkg::WB_3: begin
                wb_active  = 1'b1;
                wb_word    = 2'd3;
                next_state = cache_pkg::FILL_0;
            end
            cache_pkg::FILL_0: begin
                rd_issue   = 1'b1;
                next_state = cache_pkg::FILL_1;
            end
            cache_pkg::FILL_1: begin
                rd_issue   = 1'b1;
                issue_word = 2'd1;
                next_state = cache_pkg::FILL_2;
            end
            // Read issue and data return overlap for two cycles
            cache_pkg::FILL_2: begin
                rd_issue   = 1'b1;
                issue_word = 2'd2;
                fill_land  = 1'b1;
                next_state = cache_pkg::FILL_3;
            end
            cache_pkg::FILL_3: begin
                rd_issue   = 1'b1;
                issue_word = 2'd3;
                fill_land  = 1'b1;
                land_word  = 2'd1;
                next_state = cache_pkg::FILL_4;
            end
            cache_pkg::FILL_4: begin
                fill_land  = 1'b1;
                land_word  = 2'd2;
                next_state = cache_pkg::FILL_5;
            end
            cache_pkg::FILL_5: begin
                fill_land  = 1'b1;
                land_word  = 2'd3;
                next_state = cache_pkg::IDLE;
            end
            default: next_state = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= cache_pkg::IDLE;
            vic_way_q <= 1'b0;
            is_wr_q   <= 1'b0;
        end else begin
            state <= next_state;
            if (compare && !hit) begin
                vic_way_q <= victim_way;
                is_wr_q   <= (state == cache_pkg::COMP_WR);
            end
        end
    end

    assign fill_hit_word = fill_land && (land_word == req_word);

    always_ff @(posedge clk) begin
        if (fill_hit_word) rd_word_q <= mem_bus.rdata;
    end

    always_comb begin
        way_bus.enable   = compare || wb_active || fill_land;
        way_bus.way      = compare ? hit_way : vic_way_q;
        way_bus.index    = req_idx;
        way_bus.tag      = req_tag;
        way_bus.comp     = compare;
        way_bus.write    = ((state == cache_pkg::COMP_WR) && hit) || fill_land;
        way_bus.valid_in = fill_land;
        way_bus.dirty_in = fill_land && is_wr_q && (land_word == 2'd3);
        way_bus.offset   = addr[cache_pkg::OFS_W-1:0];
        way_bus.wdata    = data_in;
        if (wb_active) way_bus.offset = {wb_word, 1'b0};
        if (fill_land) begin
            way_bus.offset = {land_word, 1'b0};
            // Write miss merges the new word into the incoming line
            way_bus.wdata  = (is_wr_q && fill_hit_word) ? data_in : mem_bus.rdata;
        end
    end

    always_comb begin
        mem_bus.op    = cache_pkg::NONE;
        mem_bus.addr  = '0;
        mem_bus.wdata = way_bus.rdata[vic_way_q];
        if (wb_active) begin
            mem_bus.op   = cache_pkg::WRITE;
            mem_bus.addr = {victim_tag, req_idx, wb_word, 1'b0}; // Victim line address
        end else if (rd_issue) begin
            mem_bus.op   = cache_pkg::READ;
            mem_bus.addr = {req_tag, req_idx, issue_word, 1'b0};
        end
    end

    assign fill_done = (state == cache_pkg::FILL_5);
    assign done      = (compare && hit) || fill_done;
    assign cache_hit = compare && hit;
    assign stall     = (state != cache_pkg::IDLE);

    // Requested word may arrive in the very cycle that completes the fill
    assign data_out = fill_done ? (fill_hit_word ? mem_bus.rdata : rd_word_q) :
                      way_bus.rdata[hit_way];

endmodule

/* design/main_mem.sv */
module main_mem (
    input logic clk,
    mem_if.mem  mem_bus
);

    logic [cache_pkg::WORD_W-1:0] mem [cache_pkg::MEM_WORDS];
    logic [cache_pkg::ADDR_W-2:0] pipe_addr [cache_pkg::MEM_LAT];
    logic [cache_pkg::MEM_LAT-1:0] pipe_vld;

    // Each word starts as its own word address scrambled by the key
    initial begin
        for (int i = 0; i < cache_pkg::MEM_WORDS; i++) begin
            mem[i] = i[cache_pkg::WORD_W-1:0] ^ cache_pkg::MEM_INIT_KEY;
        end
    end

    always @(posedge clk) begin
        if (mem_bus.op == cache_pkg::WRITE) begin
            mem[mem_bus.addr[cache_pkg::ADDR_W-1:1]] <= mem_bus.wdata;
        end
    end

    // Read pipeline, a new read can enter every cycle
    always_ff @(posedge clk) begin
        pipe_vld     <= {pipe_vld[cache_pkg::MEM_LAT-2:0], mem_bus.op == cache_pkg::READ};
        pipe_addr[0] <= mem_bus.addr[cache_pkg::ADDR_W-1:1];
        for (int s = 1; s < cache_pkg::MEM_LAT; s++) begin
            pipe_addr[s] <= pipe_addr[s-1];
        end
    end

    assign mem_bus.rdata = pipe_vld[cache_pkg::MEM_LAT-1] ?
                           mem[pipe_addr[cache_pkg::MEM_LAT-1]] : '0;

endmodule

/* design/cache_top.sv */
`include "cache_defs.svh"

module cache_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [`CACHE_ADDR_W-1:0] addr,
    input  logic [`CACHE_WORD_W-1:0] data_in,
    input  logic                     rd,
    input  logic                     wr,
    output logic [`CACHE_WORD_W-1:0] data_out,
    output logic                     done,
    output logic                     stall,
    output logic                     cache_hit
);

    logic                        hit;
    logic                        hit_way;
    logic                        victim_way;
    logic                        victim_dirty;
    logic                        fill_done;
    logic [cache_pkg::TAG_W-1:0] victim_tag;

    cache_way_if way_bus ();
    mem_if       mem_bus ();

    cache_ctrl cache_ctrl_inst (
        .clk, .arst_n, .addr, .data_in, .rd, .wr,
        .way_bus(way_bus.ctrl), .mem_bus(mem_bus.ctrl),
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .fill_done, .data_out, .done, .stall, .cache_hit
    );

    cache_lookup cache_lookup_inst (
        .clk, .arst_n, .fill_done, .way_bus(way_bus.lookup),
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
    );

    cache_way_array cache_way_array_inst (.clk, .arst_n, .way_bus(way_bus.array));

    main_mem main_mem_inst (.clk, .mem_bus(mem_bus.mem));

endmodule

/* sim/clk_gen.sv */
module clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // Period of 20 time units
    end

endmodule

/* sim/cache_sva.sv */
module cache_sva (
    input logic                    clk,
    input logic                    arst_n,
    input cache_pkg::cache_state_e state,
    input logic                    done,
    input logic                    stall,
    input logic                    rd,
    input logic                    wr,
    input logic                    rd_issue,
    input cache_pkg::mem_op_e      mem_op
);

    logic in_compare;

    assign in_compare = (state == cache_pkg::COMP_RD) || (state == cache_pkg::COMP_WR);

    // A completed access either hit in compare or ended a stalled miss
    done_after_stall_or_compare: assert property (
        @(posedge clk) disable iff (!arst_n) done |-> ($past(stall) || in_compare)
    ) else $error("done raised without a stall or compare state before it");

    // A due fill read reaches the memory and never shares its cycle with a write-back
    fill_read_issued: assert property (
        @(posedge clk) disable iff (!arst_n) rd_issue |-> (mem_op == cache_pkg::READ)
    ) else $error("fill read displaced by another memory operation in the same cycle");

    one_request_in_idle: assert property (
        @(posedge clk) disable iff (!arst_n) (state == cache_pkg::IDLE) |-> !(rd && wr)
    ) else $error("rd and wr both high while the controller is idle");

endmodule

bind cache_ctrl cache_sva cache_sva_inst (
    .clk, .arst_n, .state, .done, .stall, .rd, .wr, .rd_issue, .mem_op(mem_bus.op)
);

/* sim/cache_tb.sv */
`include "cache_defs.svh"

module cache_tb;

    typedef struct {
        logic                     is_wr;
        logic [`CACHE_ADDR_W-1:0] addr;
        logic                     exp_hit;
        int                       exp_cycles;
        logic [`CACHE_WORD_W-1:0] wdata;
        logic [`CACHE_WORD_W-1:0] exp_data;
    } access_t;

    logic                     clk;
    logic                     arst_n;
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [`CACHE_WORD_W-1:0] data_in;
    logic                     rd;
    logic                     wr;
    logic [`CACHE_WORD_W-1:0] data_out;
    logic                     done;
    logic                     stall;
    logic                     cache_hit;

    access_t                  tests [$];
    logic [`CACHE_WORD_W-1:0] shadow [int]; // Words written so far, keyed by word address
    int                       error_count = 0;
    int                       failed_tests = 0;
    int                       cycle_count = 0;
    int                       cycle_limit = 0;

    clk_gen clk_gen_inst (.clk);

    cache_top cache_top_inst (
        .clk, .arst_n, .addr, .data_in, .rd, .wr, .data_out, .done, .stall, .cache_hit
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Run stopped after %0d cycles before the test list finished", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Flat memory view that cache and backing store together must present
    function automatic logic [`CACHE_WORD_W-1:0] memory_word(input logic [`CACHE_ADDR_W-1:0] a);
        int wa;
        wa = int'(a >> 1);
        if (shadow.exists(wa)) return shadow[wa];
        return {1'b0, a[`CACHE_ADDR_W-1:1]} ^ cache_pkg::MEM_INIT_KEY;
    endfunction

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic add_access(input logic is_wr, input logic [`CACHE_ADDR_W-1:0] a,
                              input logic exp_hit, input int exp_cycles);
        access_t t;
        t.is_wr      = is_wr;
        t.addr       = a;
        t.exp_hit    = exp_hit;
        t.exp_cycles = exp_cycles;
        t.wdata      = '0;
        t.exp_data   = '0;
        tests.push_back(t);
    endtask

    task automatic fill_expected();
        access_t t;
        foreach (tests[n]) begin
            t = tests[n];
            if (t.is_wr) begin
                t.wdata = 16'($urandom());
                // New value differs from the old word so a lost write shows on read back
                if (t.wdata == memory_word(t.addr)) t.wdata = ~t.wdata;
                shadow[int'(t.addr >> 1)] = t.wdata;
            end else begin
                t.exp_data = memory_word(t.addr);
            end
            tests[n] = t;
        end
    endtask

    task automatic check_reset_outputs();
        int errors_before;
        errors_before = error_count;
        compare_bit("stall", stall, 1'b0);
        compare_bit("done", done, 1'b0);
        compare_bit("cache_hit", cache_hit, 1'b0);
        if (error_count != errors_before) failed_tests++;
        $display("test reset: %s", (error_count == errors_before) ? "ok" : "failed");
    endtask

    task automatic run_access(input int n);
        access_t t;
        int      cycles;
        int      errors_before;
        t = tests[n];
        errors_before = error_count;
        cycles  = 0;
        addr    = t.addr;
        data_in = t.wdata;
        rd      = !t.is_wr;
        wr      = t.is_wr;
        do begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
            compare_bit("stall", stall, 1'b1); // Busy from the compare cycle until done
        end while (done !== 1'b1);
        if (cycles != t.exp_cycles) begin
            $display("MISMATCH at %0t: done cycles got %0d expected %0d",
                     $time, cycles, t.exp_cycles);
            error_count++;
        end
        compare_bit("cache_hit", cache_hit, t.exp_hit);
        if (!t.is_wr && data_out !== t.exp_data) begin
            $display("MISMATCH at %0t: data_out got %h expected %h",
                     $time, data_out, t.exp_data);
            error_count++;
        end
        rd = 1'b0;
        wr = 1'b0;
        @(posedge clk);
        @(negedge clk);
        compare_bit("stall", stall, 1'b0);
        compare_bit("done", done, 1'b0); // done is a one cycle pulse
        if (error_count != errors_before) failed_tests++;
        $display("test %0d %s %h: %s", n, t.is_wr ? "write" : "read", t.addr,
                 (error_count == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        arst_n   = 1'b0;
        addr     = '0;
        data_in  = '0;
        rd       = 1'b0;
        wr       = 1'b0;
        void'($urandom(32'h3783));

        // Set 5 holds tags 1, 2 and 3 in turn
        add_access(1'b0, 16'h082C, 1'b0, 7);  // Cold read miss into way 0
        add_access(1'b0, 16'h0828, 1'b1, 1);
        add_access(1'b1, 16'h082E, 1'b1, 1);  // Write hit makes way 0 dirty
        add_access(1'b0, 16'h082E, 1'b1, 1);
        add_access(1'b0, 16'h102A, 1'b0, 7);  // Way 1 still empty
        add_access(1'b0, 16'h1828, 1'b0, 11); // Victim bit picks the dirty way 0
        add_access(1'b0, 16'h082E, 1'b0, 7);  // Written word comes back from memory
        add_access(1'b0, 16'h1828, 1'b1, 1);  // Tag 3 kept since the victim bit moved to way 1
        add_access(1'b1, 16'h204A, 1'b0, 7);  // Write miss on set 9
        add_access(1'b0, 16'h2048, 1'b1, 1);
        add_access(1'b0, 16'h204A, 1'b1, 1);
        add_access(1'b0, 16'h082E, 1'b1, 1);
        fill_expected();
        cycle_limit = tests.size() * 12 + 50;

        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_reset_outputs();

        foreach (tests[n]) begin
            run_access(n);
        end

        $display("%0d tests run, %0d failed, %0d errors",
                 tests.size() + 1, failed_tests, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* cache_assoc.f */
+incdir+include
design/cache_pkg.sv
design/cache_if.sv
design/cache_way_array.sv
design/cache_lookup.sv
design/cache_ctrl.sv
design/main_mem.sv
design/cache_top.sv
sim/clk_gen.sv
sim/cache_sva.sv
sim/cache_tb.sv
